/* Makefile */
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/alu.sv */
/*
 * Combinational RV32I ALU with a zero flag on the result
 */

`timescale 1ns/1ps

module alu import rv_pkg::*; (
  input  alu_function_t   alu_function,
  input  logic [XLEN-1:0] operand_a,
  input  logic [XLEN-1:0] operand_b,
  output logic [XLEN-1:0] result,
  output logic            result_equal_zero
);

  logic [4:0] shamt;
  logic       less_signed;
  logic       less_unsigned;

  // Only the low five bits shift on RV32
  assign shamt = operand_b[4:0];

  assign less_signed   = $signed(operand_a) < $signed(operand_b);
  assign less_unsigned = operand_a < operand_b;

  always_comb begin
    case (alu_function)
      ALU_ADD:  result = operand_a + operand_b;
      ALU_SUB:  result = operand_a - operand_b;
      ALU_SLL:  result = operand_a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, less_signed};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, less_unsigned};
      ALU_XOR:  result = operand_a ^ operand_b;
      ALU_SRL:  result = operand_a >> shamt;
      ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
      ALU_OR:   result = operand_a | operand_b;
      ALU_AND:  result = operand_a & operand_b;
      default:  result = '0;
    endcase
  end

  // Branch decisions are taken from this flag
  assign result_equal_zero = (result == '0);

endmodule

/* design/ctrl_if.sv */
/*
 * Control interface between control unit and data path
 */

`timescale 1ns/1ps

interface ctrl_if import rv_pkg::*; ();

  // Levels from the control unit
  logic            pc_write_enable;
  logic            regfile_write_enable;
  logic            alu_operand_a_select;
  logic            alu_operand_b_select;
  wb_select_t      reg_writeback_select;
  next_pc_select_t next_pc_select;
  alu_function_t   alu_function;

  // Decoded fields and ALU flag back from the data path
  opcode_t         inst_opcode;
  logic [2:0]      inst_funct3;
  logic [6:0]      inst_funct7;
  logic            alu_result_equal_zero;

  modport control (
    output pc_write_enable, regfile_write_enable, alu_operand_a_select,
           alu_operand_b_select, reg_writeback_select, next_pc_select, alu_function,
    input  inst_opcode, inst_funct3, inst_funct7, alu_result_equal_zero
  );

  modport datapath (
    input  pc_write_enable, regfile_write_enable, alu_operand_a_select,
           alu_operand_b_select, reg_writeback_select, next_pc_select, alu_function,
    output inst_opcode, inst_funct3, inst_funct7, alu_result_equal_zero
  );

endinterface

/* design/immediate_generator.sv */
/*
 * Immediate generator for the I, S, B, U and J formats
 */

`timescale 1ns/1ps

module immediate_generator import rv_pkg::*; (
  input  logic [31:0]     inst,
  output logic [XLEN-1:0] immediate
);

  opcode_t opcode;

  assign opcode = opcode_t'(inst[6:0]);

  always_comb begin
    case (opcode)
      LOAD, OP_IMM, JALR:
        immediate = {{21{inst[31]}}, inst[30:20]};
      STORE:
        immediate = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      // B and J carry an implicit zero in bit 0
      BRANCH:
        immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      LUI, AUIPC:
        immediate = {inst[31:12], 12'b0};
      JAL:
        immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

endmodule

/* design/regfile.sv */
/*
 * Register file, 32 x 32, two read ports and one write port
 */

`timescale 1ns/1ps

module regfile import rv_pkg::*; (
  input  logic                  clock,
  input  logic [REG_ADDR_W-1:0] rs1_address,
  input  logic [REG_ADDR_W-1:0] rs2_address,
  input  logic [REG_ADDR_W-1:0] rd_address,
  input  logic [XLEN-1:0]       rd_data,
  input  logic                  write_enable,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (write_enable && rd_address != '0) begin
      regs[rd_address] <= rd_data;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

endmodule

/* design/rv_core.sv */
/*
 * Top level of the single-cycle RV32I core, control unit and data path
 */

`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter logic [XLEN-1:0] INITIAL_PC = '0
) (
  input  logic            clock,
  input  logic            rst,
  input  logic [31:0]     inst,
  input  logic [XLEN-1:0] data_mem_read_data,
  output logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] data_mem_address,
  output logic [XLEN-1:0] data_mem_write_data,
  output logic            data_mem_write_enable
);

  ctrl_if ctl ();

  singlecycle_control u_control (
    .rst                   (rst),
    .ctl                   (ctl.control),
    .data_mem_write_enable (data_mem_write_enable)
  );

  singlecycle_datapath #(
    .INITIAL_PC (INITIAL_PC)
  ) u_datapath (
    .clock               (clock),
    .rst                 (rst),
    .inst                (inst),
    .data_mem_read_data  (data_mem_read_data),
    .ctl                 (ctl.datapath),
    .pc                  (pc),
    .data_mem_address    (data_mem_address),
    .data_mem_write_data (data_mem_write_data)
  );

endmodule

/* design/rv_pkg.sv */
/*
 * Shared definitions for the single-cycle RV32I core: data and register
 * address widths, major opcodes, ALU functions and the mux selects
 */

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // ----------------------------------------------------------------------
  // Major opcodes, bits 6:0 of the instruction
  // ----------------------------------------------------------------------
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011
  } opcode_t;

  // ALU operations
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_SLL  = 5'd2,
    ALU_SLT  = 5'd3,
    ALU_SLTU = 5'd4,
    ALU_XOR  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_OR   = 5'd8,
    ALU_AND  = 5'd9
  } alu_function_t;

  // ----------------------------------------------------------------------
  // Data path mux selects
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_PC_PLUS_4, WB_IMM} wb_select_t;

  typedef enum logic [1:0] {NPC_PLUS_4, NPC_BRANCH, NPC_JALR} next_pc_select_t;

endpackage

/* design/singlecycle_control.sv */
/*
 * Control unit: main decoder, ALU function decoder and branch decision
 */

`timescale 1ns/1ps

module singlecycle_control import rv_pkg::*; (
  input  logic  rst,
  ctrl_if.control ctl,
  output logic  data_mem_write_enable
);

  logic branch_taken;
  logic shift_arith;

  // Maps funct3 of OP and OP-IMM onto an ALU operation
  function automatic alu_function_t decode_alu(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // OP-IMM has no SUB, bit 30 only picks SRA
  assign shift_arith = (ctl.inst_funct3 == 3'b101) && ctl.inst_funct7[5];

  // ----------------------------------------------------------------------
  // Branch decision
  // ----------------------------------------------------------------------
  // BEQ, BGE and BGEU take on a zero result, the others on non-zero
  assign branch_taken = ctl.alu_result_equal_zero ^ (ctl.inst_funct3[2] ^ ctl.inst_funct3[0]);

  // ----------------------------------------------------------------------
  // Main decoder
  // ----------------------------------------------------------------------
  always_comb begin
    ctl.pc_write_enable      = 1'b1;
    ctl.regfile_write_enable = 1'b0;
    ctl.alu_operand_a_select = 1'b0;
    ctl.alu_operand_b_select = 1'b0;
    ctl.reg_writeback_select = WB_ALU;
    ctl.next_pc_select       = NPC_PLUS_4;
    ctl.alu_function         = ALU_ADD;
    data_mem_write_enable    = 1'b0;

    case (ctl.inst_opcode)
      LUI: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = WB_IMM;
      end
      AUIPC: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = 1'b1;
        ctl.alu_operand_b_select = 1'b1;
      end
      JAL: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = WB_PC_PLUS_4;
        ctl.next_pc_select       = NPC_BRANCH;
      end
      JALR: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = 1'b1;
        ctl.reg_writeback_select = WB_PC_PLUS_4;
        ctl.next_pc_select       = NPC_JALR;
      end
      BRANCH: begin
        case (ctl.inst_funct3[2:1])
          2'b00:   ctl.alu_function = ALU_SUB;
          2'b10:   ctl.alu_function = ALU_SLT;
          default: ctl.alu_function = ALU_SLTU;
        endcase
        ctl.next_pc_select = branch_taken ? NPC_BRANCH : NPC_PLUS_4;
      end
      LOAD: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = 1'b1;
        ctl.reg_writeback_select = WB_MEM;
      end
      STORE: begin
        ctl.alu_operand_b_select = 1'b1;
        data_mem_write_enable    = 1'b1;
      end
      OP: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_function         = decode_alu(ctl.inst_funct3, ctl.inst_funct7[5]);
      end
      OP_IMM: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = 1'b1;
        ctl.alu_function         = decode_alu(ctl.inst_funct3, shift_arith);
      end
      // Illegal opcode parks the core on this PC
      default: ctl.pc_write_enable = 1'b0;
    endcase

    if (rst) begin
      ctl.regfile_write_enable = 1'b0;
      data_mem_write_enable    = 1'b0;
    end
  end

endmodule

/* design/singlecycle_datapath.sv */
/*
 * Single-cycle data path: PC register, register file, immediates, ALU,
 * operand, next-PC and writeback selection, data memory address and data
 */

`timescale 1ns/1ps

module singlecycle_datapath import rv_pkg::*; #(
  parameter logic [XLEN-1:0] INITIAL_PC = '0
) (
  input  logic            clock,
  input  logic            rst,
  input  logic [31:0]     inst,
  input  logic [XLEN-1:0] data_mem_read_data,
  ctrl_if.datapath        ctl,
  output logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] data_mem_address,
  output logic [XLEN-1:0] data_mem_write_data
);

  logic [REG_ADDR_W-1:0] inst_rd;
  logic [REG_ADDR_W-1:0] inst_rs1;
  logic [REG_ADDR_W-1:0] inst_rs2;

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] immediate;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] alu_result;
  logic            alu_zero;
  logic [XLEN-1:0] pc_plus_4;
  logic [XLEN-1:0] pc_plus_immediate;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] rd_data;

  // ----------------------------------------------------------------------
  // Instruction fields
  // ----------------------------------------------------------------------
  assign ctl.inst_opcode = opcode_t'(inst[6:0]);
  assign ctl.inst_funct3 = inst[14:12];
  assign ctl.inst_funct7 = inst[31:25];
  assign inst_rd         = inst[11:7];
  assign inst_rs1        = inst[19:15];
  assign inst_rs2        = inst[24:20];

  immediate_generator u_immediate_generator (
    .inst      (inst),
    .immediate (immediate)
  );

  regfile u_regfile (
    .clock        (clock),
    .rs1_address  (inst_rs1),
    .rs2_address  (inst_rs2),
    .rd_address   (inst_rd),
    .rd_data      (rd_data),
    .write_enable (ctl.regfile_write_enable),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  // ALU operands, PC for AUIPC and immediate for I and S types
  assign operand_a = ctl.alu_operand_a_select ? pc : rs1_data;
  assign operand_b = ctl.alu_operand_b_select ? immediate : rs2_data;

  alu u_alu (
    .alu_function      (ctl.alu_function),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (alu_zero)
  );

  assign ctl.alu_result_equal_zero = alu_zero;

  // ----------------------------------------------------------------------
  // Next PC and program counter
  // ----------------------------------------------------------------------
  assign pc_plus_4         = pc + 32'd4;
  assign pc_plus_immediate = pc + immediate;

  always_comb begin
    case (ctl.next_pc_select)
      NPC_BRANCH: next_pc = pc_plus_immediate;
      NPC_JALR:   next_pc = {alu_result[XLEN-1:1], 1'b0};
      default:    next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= INITIAL_PC;
    end else if (ctl.pc_write_enable) begin
      pc <= next_pc;
    end
  end

  // Writeback source
  always_comb begin
    case (ctl.reg_writeback_select)
      WB_ALU:       rd_data = alu_result;
      WB_MEM:       rd_data = data_mem_read_data;
      WB_PC_PLUS_4: rd_data = pc_plus_4;
      WB_IMM:       rd_data = immediate;
      default:      rd_data = '0;
    endcase
  end

  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

endmodule

/* testbench/rv_core_checker.sv */
/*
 * Instruction-set model of RV32I that runs beside the core and
 * compares pc and every store each cycle
 */

`timescale 1ns/1ps

module rv_core_checker #(
  parameter logic [31:0] INITIAL_PC = 32'h0
) (
  input  logic        clock,
  input  logic        rst,
  input  logic [31:0] inst,
  input  logic [31:0] pc,
  input  logic [31:0] data_mem_address,
  input  logic [31:0] data_mem_write_data,
  input  logic        data_mem_write_enable,
  input  logic [31:0] data_mem_read_data,
  output int          error_count
);

  logic [31:0] regs [0:31];
  logic [31:0] mem_model [logic [31:0]];
  logic [31:0] model_pc, npc, wdata, addr, rs1v, rs2v;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic        wr, exp_we, taken;

  initial begin
    error_count = 0;
    regs[0] = '0;
  end

  task automatic compare(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("error %s: expected %08h, actual %08h", test, expected, actual);
    end
  endtask

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $unsigned($signed(a) >>> b[4:0]);
        else return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // ------------------------------------------------------------------
  // One instruction per clock
  // ------------------------------------------------------------------
  always @(posedge clock) begin
    if (rst) begin
      model_pc = INITIAL_PC;
      compare("reset_store_strobe", 32'd0, {31'b0, data_mem_write_enable});
    end else begin
      compare("pc", model_pc, pc);
      // Resync so one fault does not flood the log
      model_pc = pc;
      rs1v  = regs[inst[19:15]];
      rs2v  = regs[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_u = {inst[31:12], 12'b0};
      imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      npc    = model_pc + 32'd4;
      wr     = 1'b0;
      exp_we = 1'b0;
      wdata  = '0;
      case (inst[6:0])
        7'h37: begin wr = 1'b1; wdata = imm_u; end
        7'h17: begin wr = 1'b1; wdata = model_pc + imm_u; end
        7'h6f: begin wr = 1'b1; wdata = npc; npc = model_pc + imm_j; end
        7'h67: begin
          wr = 1'b1;
          wdata = npc;
          npc = (rs1v + imm_i) & ~32'd1;
        end
        7'h63: begin
          case (inst[14:12])
            3'd0: taken = rs1v == rs2v;
            3'd1: taken = rs1v != rs2v;
            3'd4: taken = $signed(rs1v) < $signed(rs2v);
            3'd5: taken = $signed(rs1v) >= $signed(rs2v);
            3'd6: taken = rs1v < rs2v;
            default: taken = rs1v >= rs2v;
          endcase
          if (taken) npc = model_pc + imm_b;
        end
        7'h03: begin
          addr = rs1v + imm_i;
          compare("load_address", addr, data_mem_address);
          wr = 1'b1;
          wdata = mem_model.exists(addr) ? mem_model[addr] : data_mem_read_data;
        end
        7'h23: exp_we = 1'b1;
        7'h13: begin
          wr = 1'b1;
          wdata = alu_model(inst[14:12], inst[14:12] == 3'd5 && inst[30], rs1v, imm_i);
        end
        7'h33: begin wr = 1'b1; wdata = alu_model(inst[14:12], inst[30], rs1v, rs2v); end
        // Illegal opcode, the core parks here
        default: npc = model_pc;
      endcase
      compare("store_strobe", {31'b0, exp_we}, {31'b0, data_mem_write_enable});
      if (exp_we) begin
        addr = rs1v + imm_s;
        compare("store_address", addr, data_mem_address);
        compare("store_data", rs2v, data_mem_write_data);
        mem_model[addr] = rs2v;
      end
      if (wr && inst[11:7] != 5'd0) regs[inst[11:7]] = wdata;
      model_pc = npc;
    end
  end

endmodule

/* testbench/rv_core_props.sv */
/*
 * Concurrent assertions on the rv_core ports, bound to the core
 */

`timescale 1ns/1ps

module rv_core_props #(
  parameter logic [31:0] INITIAL_PC = 32'h0
) (
  input logic        clock,
  input logic        rst,
  input logic [31:0] pc,
  input logic        data_mem_write_enable
);

  int fail_count = 0;

  reset_pc: assert property (@(posedge clock) rst |=> pc == INITIAL_PC)
    else begin
      $error("pc is not the initial value after reset");
      fail_count++;
    end

  no_store_in_reset: assert property (@(posedge clock) rst |-> !data_mem_write_enable)
    else begin
      $error("store strobe high during reset");
      fail_count++;
    end

  pc_aligned: assert property (@(posedge clock) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");
      fail_count++;
    end

endmodule

bind rv_core rv_core_props #(.INITIAL_PC(INITIAL_PC)) u_props (
  .clock                 (clock),
  .rst                   (rst),
  .pc                    (pc),
  .data_mem_write_enable (data_mem_write_enable)
);

/* testbench/tb_rv_core.sv */
/*
 * Testbench for rv_core: clock, reset, random program, instruction and
 * data memories, checker, watchdog and closing report
 */

`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] INITIAL_PC = 32'h0;
  localparam int          BODY_LEN   = 200;
  localparam logic [11:0] DATA_BASE  = 12'h100;

  logic        clock = 1'b0;
  logic        rst;
  logic [31:0] inst, data_mem_read_data, pc, data_mem_address, data_mem_write_data;
  logic        data_mem_write_enable;
  logic [31:0] imem [0:511];
  logic [31:0] dmem [0:63];
  integer      seed;
  int          prog_len;
  int          checker_errors;
  logic        prog_ready = 1'b0;

  always #50 clock = ~clock;

  // Memories read with no clock cycle
  assign inst               = imem[pc[10:2]];
  assign data_mem_read_data = dmem[data_mem_address[7:2]];

  always @(posedge clock) begin
    if (data_mem_write_enable) dmem[data_mem_address[7:2]] <= data_mem_write_data;
  end

  rv_core #(.INITIAL_PC(INITIAL_PC)) u_rv_core (.*);

  rv_core_checker #(.INITIAL_PC(INITIAL_PC)) u_checker (.*, .error_count(checker_errors));

  function automatic int pick(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // ------------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------------
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // x31 is the data base, x29 the JALR target, random rd stays in x0..x28
  task automatic gen_program();
    int idx, last_jump;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [4:0]  rd;
    // Leading SW of x0 sits at the reset PC while rst is held
    imem[0] = enc_s(DATA_BASE, 5'd0, 5'd0);
    idx = 1;
    last_jump = -10;
    for (int r = 1; r < 32; r++) begin
      imem[idx] = {20'($random(seed)), 5'(r), 7'h37};
      imem[idx+1] = enc_i(r == 31 ? DATA_BASE : 12'($random(seed)), 5'(r), 3'd0, 5'(r), 7'h13);
      if (r == 31) imem[idx] = {20'd0, 5'd31, 7'h37};
      idx += 2;
    end
    for (int n = 0; n < BODY_LEN; n++) begin
      f3  = 3'(pick(8));
      rd  = 5'(pick(29));
      imm = 12'(pick(4096));
      case (pick(8))
        0, 1: imem[idx] = enc_i({((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00,
                                 5'(pick(32))}, 5'(pick(32)), f3, rd, 7'h33);
        2: begin
          if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
          if (f3 == 3'd5) imm = {pick(2) == 1 ? 7'h20 : 7'h00, imm[4:0]};
          imem[idx] = enc_i(imm, 5'(pick(32)), f3, rd, 7'h13);
        end
        3: imem[idx] = {20'($random(seed)), rd, pick(2) == 1 ? 7'h37 : 7'h17};
        4: imem[idx] = enc_s(12'(pick(16) * 4), 5'(pick(32)), 5'd31);
        5: begin
          // Load, then expose the loaded word through a store
          rd = 5'(1 + pick(28));
          imem[idx] = enc_i(12'(pick(16) * 4), 5'd31, 3'd2, rd, 7'h03);
          idx++;
          imem[idx] = enc_s(12'(pick(16) * 4), rd, 5'd31);
        end
        6: begin
          if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
          imem[idx] = enc_b(13'((1 + pick(3)) * 4), 5'(pick(32)), 5'(pick(32)), f3);
          last_jump = idx;
        end
        default: begin
          if (idx - last_jump >= 3) begin
            imem[idx] = enc_i(12'((idx + 2 + pick(3)) * 4 + 1), 5'd0, 3'd0, 5'd29, 7'h13);
            idx++;
            imem[idx] = enc_i(12'd0, 5'd29, 3'd0, rd, 7'h67);
          end else begin
            imem[idx] = enc_j(21'((1 + pick(3)) * 4), rd);
          end
          last_jump = idx;
        end
      endcase
      idx++;
    end
    // Opcode zero is illegal and ends the program
    imem[idx] = 32'h0;
    prog_len = idx + 1;
  endtask

  initial begin
    seed = 32'h55299781;
    rst  = 1'b1;
    for (int i = 0; i < 512; i++) imem[i] = 32'h0;
    for (int i = 0; i < 64; i++) dmem[i] = (32'(DATA_BASE) + 32'(i * 4)) * 32'h9e3779b1;
    gen_program();
    prog_ready = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    while (inst[6:0] != 7'h00) @(negedge clock);
    // Stay parked for a few cycles on the illegal opcode
    repeat (8) @(negedge clock);
    $display("checker errors %0d, assertion failures %0d",
             checker_errors, u_rv_core.u_props.fail_count);
    if (checker_errors + u_rv_core.u_props.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog allows one cycle per instruction plus reset and margin
  initial begin
    wait (prog_ready);
    #((prog_len + 3 + 20) * 100);
    $display("timeout: the core did not reach the end of the program in time");
    $display("Regression failed");
    $finish;
  end

endmodule

/* vlog.f */
design/rv_pkg.sv
design/ctrl_if.sv
design/alu.sv
design/immediate_generator.sv
design/regfile.sv
design/singlecycle_control.sv
design/singlecycle_datapath.sv
design/rv_core.sv
testbench/rv_core_props.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv
